// File: source/video_pkg.sv
package video_pkg;

    // one pixel as held in tile rows and line buffers.
    typedef struct packed {
        logic [4:0] palette; // colour bank.
        logic [3:0] pen;     // index inside the bank.
    } pixel_t;

    // renderer to mixer, one pixel per strobe.
    typedef struct packed {
        logic       wr;   // store pix at addr.
        logic [8:0] addr; // screen x.
        pixel_t     pix;
    } layer_wr_t;

    // host write into a tile row.
    typedef struct packed {
        logic       wr;
        logic [1:0] layer; // 0, 1 or 2.
        logic [5:0] index; // tile slot in the row.
        pixel_t     entry; // solid colour of the tile.
    } tile_wr_t;

    // mixer to frame buffer, held until accepted.
    typedef struct packed {
        logic       wr;
        logic [8:0] addr;
        pixel_t     pix;
    } line_wr_t;

    // mixer sequencing.
    typedef enum logic [1:0] {
        COLLECT, // layers paint into the line buffers.
        DUMP,    // merged line goes out.
        DONE     // line finished, waiting for start.
    } mix_state_e;

    localparam logic [3:0] TRANSPARENT_PEN    = 4'hf;
    localparam int         DEFAULT_LINE_WIDTH = 448;
    localparam int         TILE_SHIFT         = 3; // 8 pixel tiles.

endpackage

// File: source/layer_renderer.sv
`timescale 1ns/1ps

// one scroll layer.
// a row of 64 solid tiles, painted one pixel per clock after start.
module layer_renderer import video_pkg::*; #(
    parameter int line_width = DEFAULT_LINE_WIDTH
) (
    input  logic      clk,
    input  logic      rst,
    input  tile_wr_t  tile_wr,    // host port, shared by all layers.
    input  logic [1:0] layer_id,  // which host writes belong here.
    input  logic [8:0] hscroll,   // static during a line.
    input  logic      start,
    output layer_wr_t lay_wr,
    output logic      layer_done
);

    // last screen x of the line.
    localparam logic [8:0] last_x = 9'(line_width - 1);

    pixel_t     tile_ram [0:63]; // tile row, undefined until written.
    logic       active;          // painting the line.
    logic [8:0] x;               // screen x being painted.
    logic [8:0] sx;              // scrolled x, wraps at 512.
    logic [5:0] tile_idx;        // tile under sx.
    logic       tile_sel;        // host write targets this layer.

    assign tile_sel = tile_wr.wr && (tile_wr.layer == layer_id);

    // host writes, no reset on the row itself.
    always_ff @(posedge clk) begin
        if (tile_sel) begin
            tile_ram[tile_wr.index] <= tile_wr.entry;
        end
    end

    // 9 bit add gives the modulo 512 wrap for free.
    assign sx       = x + hscroll;
    assign tile_idx = 6'(sx >> TILE_SHIFT); // drop the in-tile column.

    // x counter.
    // start is seen in cycle 0, pixel x goes out in cycle 1+x.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            active <= 1'b0;
            x      <= 9'd0;
        end else if (start) begin
            active <= 1'b1;
            x      <= 9'd0; // restart from the left edge.
        end else if (active) begin
            if (x == last_x) begin
                active <= 1'b0; // line painted.
            end else begin
                x <= x + 9'd1;
            end
        end
    end

    // pixel write toward the mixer.
    // tiles are solid so the column inside the tile does not matter.
    always_comb begin
        lay_wr.wr   = active;
        lay_wr.addr = x;
        lay_wr.pix  = tile_ram[tile_idx];
    end

    // pulse together with the last pixel.
    assign layer_done = active && (x == last_x);

endmodule

// File: source/colour_mixer.sv
`timescale 1ns/1ps

// colour mixer.
// buffers three layer lines, merges them by fixed priority and
// hands the result to the frame buffer one pixel at a time.
module colour_mixer import video_pkg::*; #(
    parameter int line_width = DEFAULT_LINE_WIDTH
) (
    input  logic      clk,
    input  logic      rst,
    input  logic      start,
    input  layer_wr_t lay1,       // top layer.
    input  layer_wr_t lay2,
    input  layer_wr_t lay3,       // back layer.
    input  logic [2:0] layer_done,
    output line_wr_t  line_out,
    input  logic      line_wr_ok, // frame buffer takes the write.
    output logic      line_done
);

    localparam logic [8:0] last_x = 9'(line_width - 1);

    pixel_t     buf1 [0:511];       // layer line buffers.
    pixel_t     buf2 [0:511];
    pixel_t     buf3 [0:511];
    mix_state_e state;
    logic [2:0] done_q;             // sticky per layer done.
    logic [8:0] rd_addr;            // next buffer address to read.
    logic       pxl_ok;             // rd regs hold an unsent pixel.
    pixel_t     rd1, rd2, rd3;      // registered buffer reads.
    pixel_t     merged;
    logic       out_wr;             // write pending at the frame buffer.
    logic [8:0] out_addr;
    pixel_t     out_pix;
    logic       accept;             // frame buffer takes the write now.
    logic       last_wr;            // pending write is the last pixel.
    logic       rd_go;              // read the buffers this cycle.
    logic       present;            // put the merged pixel out.

    // fixed priority, pen 4'hf lets the next layer through.
    always_comb begin
        if (rd1.pen != TRANSPARENT_PEN) begin
            merged = rd1;
        end else if (rd2.pen != TRANSPARENT_PEN) begin
            merged = rd2;
        end else begin
            merged = rd3; // back layer shows even if transparent.
        end
    end

    assign accept  = out_wr && line_wr_ok;
    assign last_wr = out_addr == last_x;
    // read when nothing is pending, or as the pending write completes.
    assign rd_go   = (state == DUMP) && !start && !pxl_ok &&
                     (!out_wr || (line_wr_ok && !last_wr));
    assign present = (state == DUMP) && !start && pxl_ok;

    // control.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= COLLECT;
            done_q    <= 3'd0;
            rd_addr   <= 9'd0;
            pxl_ok    <= 1'b0;
            out_wr    <= 1'b0;
            line_done <= 1'b0;
        end else if (start) begin
            state     <= COLLECT; // new line begins.
            done_q    <= 3'd0;
            pxl_ok    <= 1'b0;
            out_wr    <= 1'b0;
            line_done <= 1'b0;
        end else begin
            case (state)
                COLLECT: begin
                    done_q <= done_q | layer_done;
                    if (&done_q) begin
                        state   <= DUMP;
                        rd_addr <= 9'd0; // dump from the left edge.
                    end
                end
                DUMP: begin
                    if (rd_go) begin
                        rd_addr <= rd_addr + 9'd1;
                        pxl_ok  <= 1'b1;
                    end
                    if (present) begin
                        out_wr <= 1'b1;
                        pxl_ok <= 1'b0;
                    end else if (accept) begin
                        out_wr <= 1'b0;
                        if (last_wr) begin
                            state     <= DONE;
                            line_done <= 1'b1; // held until next start.
                        end
                    end
                end
                default: begin
                    // DONE, idle until start.
                end
            endcase
        end
    end

    // buffers and payload, no reset.
    always_ff @(posedge clk) begin
        if (state == COLLECT) begin
            if (lay1.wr) buf1[lay1.addr] <= lay1.pix;
            if (lay2.wr) buf2[lay2.addr] <= lay2.pix;
            if (lay3.wr) buf3[lay3.addr] <= lay3.pix;
        end
        if (rd_go) begin
            rd1 <= buf1[rd_addr];
            rd2 <= buf2[rd_addr];
            rd3 <= buf3[rd_addr];
        end
        if (present) begin
            out_addr <= rd_addr - 9'd1; // rd_addr already moved on.
            out_pix  <= merged;
        end
    end

    always_comb begin
        line_out.wr   = out_wr;
        line_out.addr = out_addr;
        line_out.pix  = out_pix;
    end

endmodule

// File: source/line_video_top.sv
`timescale 1ns/1ps

// one scanline of the tile video pipeline.
// three scroll layers feed the colour mixer, which writes the frame buffer.
module line_video_top import video_pkg::*; #(
    parameter int line_width = DEFAULT_LINE_WIDTH
) (
    input  logic       clk,
    input  logic       rst,
    input  tile_wr_t   tile_wr,    // host tile writes.
    input  logic [8:0] hscroll1,
    input  logic [8:0] hscroll2,
    input  logic [8:0] hscroll3,
    input  logic       start,      // one cycle, begins a line.
    output line_wr_t   line_out,   // toward the frame buffer.
    input  logic       line_wr_ok,
    output logic       line_done
);

    layer_wr_t  lay1, lay2, lay3;  // pixel writes into the mixer.
    logic [2:0] layer_done;        // bit n is layer n+1.

    // layer 1, highest priority.
    layer_renderer #(.line_width(line_width)) u_layer1 (
        .clk        (clk),
        .rst        (rst),
        .tile_wr    (tile_wr),
        .layer_id   (2'd0),
        .hscroll    (hscroll1),
        .start      (start),
        .lay_wr     (lay1),
        .layer_done (layer_done[0])
    );

    layer_renderer #(.line_width(line_width)) u_layer2 (
        .clk        (clk),
        .rst        (rst),
        .tile_wr    (tile_wr),
        .layer_id   (2'd1),
        .hscroll    (hscroll2),
        .start      (start),
        .lay_wr     (lay2),
        .layer_done (layer_done[1])
    );

    // layer 3, the background.
    layer_renderer #(.line_width(line_width)) u_layer3 (
        .clk        (clk),
        .rst        (rst),
        .tile_wr    (tile_wr),
        .layer_id   (2'd2),
        .hscroll    (hscroll3),
        .start      (start),
        .lay_wr     (lay3),
        .layer_done (layer_done[2])
    );

    colour_mixer #(.line_width(line_width)) u_mixer (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .lay1       (lay1),
        .lay2       (lay2),
        .lay3       (lay3),
        .layer_done (layer_done),
        .line_out   (line_out),
        .line_wr_ok (line_wr_ok),
        .line_done  (line_done)
    );

endmodule

// File: tb/line_video_assert.sv
`timescale 1ns/1ps

// frame buffer port rules, bound onto the top level.
module line_video_assert import video_pkg::*; (
    input logic     clk,
    input logic     rst,
    input logic     start,
    input line_wr_t line_out,
    input logic     line_wr_ok,
    input logic     line_done
);

    int violations = 0; // read by the testbench at the end.

    // stalled write keeps its payload.
    hold_payload: assert property (
        @(posedge clk) disable iff (rst)
        (line_out.wr && !line_wr_ok) |=> ($stable(line_out.addr) && $stable(line_out.pix))
    ) else begin
        $error("frame buffer write changed while stalled");
        violations++;
    end

    no_write_when_done: assert property (
        @(posedge clk) disable iff (rst) !(line_out.wr && line_done)
    ) else begin
        $error("write presented while line_done is high");
        violations++;
    end

    // only a start clears line_done.
    done_falls_on_start: assert property (
        @(posedge clk) disable iff (rst) $fell(line_done) |-> $past(start)
    ) else begin
        $error("line_done fell without a start");
        violations++;
    end

endmodule

bind line_video_top line_video_assert u_assert (
    .clk        (clk),
    .rst        (rst),
    .start      (start),
    .line_out   (line_out),
    .line_wr_ok (line_wr_ok),
    .line_done  (line_done)
);

// File: tb/tb_line_video.sv
`timescale 1ns/1ps

// testbench for the scanline stage.
// the testbench acts as host and frame buffer, and predicts each line from shadow tiles.
module tb_line_video import video_pkg::*; ();

    localparam int line_width = 448;
    localparam int max_cycles = 20000; // six lines of render plus stalled dump.

    logic       clk;
    logic       rst;
    tile_wr_t   tile_wr;
    logic [8:0] hscroll1;
    logic [8:0] hscroll2;
    logic [8:0] hscroll3;
    logic       start;
    line_wr_t   line_out;
    logic       line_wr_ok;
    logic       line_done;

    pixel_t shadow [0:2][0:63]; // host view of the tile rows.
    int     scroll [0:2];
    pixel_t expected [0:511];
    pixel_t received [0:511];   // frame buffer contents.
    bit     written [0:511];
    int     wr_count;           // accepted writes this line.
    bit     stall_mode;
    integer seed;
    int     cycles;

    line_video_top #(.line_width(line_width)) u_dut (
        .clk        (clk),
        .rst        (rst),
        .tile_wr    (tile_wr),
        .hscroll1   (hscroll1),
        .hscroll2   (hscroll2),
        .hscroll3   (hscroll3),
        .start      (start),
        .line_out   (line_out),
        .line_wr_ok (line_wr_ok),
        .line_done  (line_done)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk; // 40 ns period.
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_pixel(input string name, input pixel_t got, input pixel_t exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input logic [8:0] got, input logic [8:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            report_failure($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
        end
    endtask

    // watchdog.
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= max_cycles) begin
            report_failure($sformatf("timeout, tests still running after %0d cycles", cycles));
        end
    end

    // frame buffer acceptance with random stalls on request.
    always @(posedge clk) begin
        if (stall_mode) begin
            line_wr_ok <= ($random(seed) & 32'd1) != 0;
        end else begin
            line_wr_ok <= 1'b1;
        end
    end

    // wr and ok are stable here and the write completes at the next rising edge.
    always @(negedge clk) begin
        if (line_out.wr === 1'b1 && line_wr_ok === 1'b1) begin
            if (line_out.addr >= line_width) begin
                report_failure($sformatf("write outside the line at address %0d",
                                         line_out.addr));
            end
            if (written[line_out.addr]) begin
                report_failure($sformatf("address %0d was written twice", line_out.addr));
            end
            check_addr("line_out.addr", line_out.addr, 9'(wr_count)); // strictly in order.
            received[line_out.addr] = line_out.pix;
            written[line_out.addr]  = 1'b1;
            wr_count                = wr_count + 1;
        end
    end

    // pixel of one layer from the tile geometry.
    function automatic pixel_t layer_pixel(input int layer, input int x);
        int sx;
        sx = (x + scroll[layer]) % 512;
        return shadow[layer][(sx >> 3) % 64];
    endfunction

    // layer 1 over layer 2 over layer 3.
    function automatic pixel_t merge_pixel(input pixel_t p1, input pixel_t p2, input pixel_t p3);
        if (p1.pen != 4'hf) return p1;
        if (p2.pen != 4'hf) return p2;
        return p3;
    endfunction

    task automatic build_expected();
        for (int x = 0; x < line_width; x++) begin
            expected[x] = merge_pixel(layer_pixel(0, x), layer_pixel(1, x), layer_pixel(2, x));
        end
    endtask

    task automatic write_tile(input int layer, input int index, input pixel_t entry);
        tile_wr_t w;
        w.wr    = 1'b1;
        w.layer = 2'(layer);
        w.index = 6'(index);
        w.entry = entry;
        shadow[layer][index] = entry;
        @(posedge clk);
        tile_wr <= w;
    endtask

    task automatic end_writes();
        @(posedge clk);
        tile_wr <= '0;
    endtask

    task automatic set_scroll(input int s1, input int s2, input int s3);
        scroll[0] = s1;
        scroll[1] = s2;
        scroll[2] = s3;
        @(posedge clk);
        hscroll1 <= 9'(s1);
        hscroll2 <= 9'(s2);
        hscroll3 <= 9'(s3);
    endtask

    // roughly a third of the pens see through.
    task automatic fill_random();
        integer r;
        pixel_t e;
        for (int l = 0; l < 3; l++) begin
            for (int i = 0; i < 64; i++) begin
                r         = $random(seed);
                e.palette = r[8:4];
                e.pen     = (r[31:16] % 3 == 0) ? 4'hf : {1'b0, r[2:0]};
                write_tile(l, i, e);
            end
        end
        end_writes();
    endtask

    // start one line and compare every pixel after line_done.
    task automatic run_line(input bit stall);
        for (int x = 0; x < 512; x++) written[x] = 1'b0;
        wr_count   = 0;
        stall_mode = stall;
        build_expected();
        @(posedge clk);
        start <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        @(negedge clk);
        check_flag("line_done", line_done, 1'b0); // dropped by start.
        while (line_done !== 1'b1) @(negedge clk);
        stall_mode = 1'b0;
        if (wr_count != line_width) begin
            report_failure($sformatf("line ended after %0d writes instead of %0d",
                                     wr_count, line_width));
        end
        for (int x = 0; x < line_width; x++) begin
            check_pixel($sformatf("line_out.pix[%0d]", x), received[x], expected[x]);
        end
    endtask

    task automatic after_reset();
        repeat (8) @(negedge clk);
        check_flag("line_out.wr", line_out.wr, 1'b0);
        check_flag("line_done", line_done, 1'b0);
        if (wr_count != 0) begin
            report_failure("a frame buffer write appeared before the first start");
        end
    endtask

    // only the back layer shows.
    task automatic back_layer_only();
        pixel_t e;
        for (int i = 0; i < 64; i++) begin
            e.palette = 5'(i);
            e.pen     = 4'hf;
            write_tile(0, i, e);
            write_tile(1, i, e);
            write_tile(2, i, pixel_t'(9'(i * 5 + 1))); // distinct per tile.
        end
        end_writes();
        set_scroll(0, 0, 0);
        run_line(1'b0);
    endtask

    task automatic priority_merge();
        fill_random();
        set_scroll(0, 0, 0);
        run_line(1'b0);
    endtask

    // 500 pushes layer 2 across the 512 wrap.
    task automatic scroll_wrap();
        set_scroll(13, 500, 77);
        run_line(1'b0);
    endtask

    // same tiles and scroll as the priority line.
    task automatic stalled_dump();
        set_scroll(0, 0, 0);
        run_line(1'b1);
    endtask

    task automatic back_to_back();
        check_flag("line_done", line_done, 1'b1); // still up from the last line.
        fill_random();
        set_scroll(200, 9, 311);
        run_line(1'b0);
        set_scroll(0, 500, 64);
        run_line(1'b1);
    endtask

    initial begin
        seed       = 32'h5f79;
        cycles     = 0;
        wr_count   = 0;
        stall_mode = 1'b0;
        rst        = 1'b1;
        start      = 1'b0;
        tile_wr    = '0;
        hscroll1   = 9'd0;
        hscroll2   = 9'd0;
        hscroll3   = 9'd0;
        line_wr_ok = 1'b1;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        after_reset();
        back_layer_only();
        priority_merge();
        scroll_wrap();
        stalled_dump();
        back_to_back();
        if (u_dut.u_assert.violations == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            report_failure($sformatf("%0d assertion violations on the frame buffer port",
                                     u_dut.u_assert.violations));
        end
    end

endmodule

// File: list.f
source/video_pkg.sv
source/layer_renderer.sv
source/colour_mixer.sv
source/line_video_top.sv
tb/line_video_assert.sv
tb/tb_line_video.sv

// File: Bender.yml
package:
  name: line_video

sources:
  - source/video_pkg.sv
  - source/layer_renderer.sv
  - source/colour_mixer.sv
  - source/line_video_top.sv
  - target: test
    files:
      - tb/line_video_assert.sv
      - tb/tb_line_video.sv
